//--- retire_top.f
isa_pkg.sv
retire_pkg.sv
retire_op_if.sv
commit_if.sv
retire_capture.sv
retire_ctrl.sv
retire_commit.sv
retire_top.sv
tb_retire_top.sv

//--- Bender.yml
package:
  name: retire_top

sources:
  - isa_pkg.sv
  - retire_pkg.sv
  - retire_op_if.sv
  - commit_if.sv
  - retire_capture.sv
  - retire_ctrl.sv
  - retire_commit.sv
  - retire_top.sv
  - target: simulation
    files:
      - tb_retire_top.sv

//--- tb_retire_top.sv
module tb_retire_top;
    import isa_pkg::*;
    import retire_pkg::*;

    localparam int TAG_W    = TAG_W_DEF;
    localparam int NUM_OPS  = 3000;                 // Random ops in the run
    localparam int DRAIN    = 2;                    // Idle cycles after the last op
    localparam int WATCHDOG = (NUM_OPS + 100) * 10; // Hard stop in time units

    typedef struct {
        logic             valid;
        logic             exc;
        logic [31:0]      instr;
        logic [31:0]      npc;
        logic [31:0]      r0;
        logic [31:0]      r1;
        logic             jmp;
        logic             wen;
        logic [TAG_W-1:0] tag;
        logic [3:0]       wmem;
        logic [31:0]      din;
        i_type            cls;
    } op_t;

    typedef struct {
        logic [3:0]           mask;
        logic [31:0]          addr;
        logic [31:0]          data;
        logic [RET_CNT_W-1:0] count;                // Live ops up to this entry
    } mem_t;

    logic clk;
    logic reset;
    logic op_valid;
    logic exception;
    logic [31:0] instruction;
    logic [31:0] npc;
    logic [31:0] result0;
    logic [31:0] result1;
    logic jump;
    logic we;
    logic [TAG_W-1:0] tag_in;
    logic [3:0] we_mem;
    logic [31:0] data_in;
    i_type i_class;
    logic irq_pending;
    logic reg_we;
    logic [31:0] wr_data;
    logic jump_out;
    logic [31:0] new_pc;
    logic raise_exception;
    except_code exception_code;
    logic machine_return;
    logic irq_ack;
    logic [TAG_W-1:0] curr_tag;
    logic [3:0] mem_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_data;
    logic [RET_CNT_W-1:0] retired_count;

    // Reference model state
    integer               seed = 32'h3636;
    logic [TAG_W-1:0]     mdl_tag = '0;             // Model retire tag
    logic [RET_CNT_W-1:0] live_cnt = '0;
    mem_t                 mem_q[$];                 // Stores waiting for the memory port
    int                   mismatch_cnt = 0;
    int                   fail_cnt = 0;

    // Expected controller outputs for the op in the controller
    logic        e_we, e_jump, e_raise, e_mret, e_irq;
    logic [31:0] e_data, e_pc;
    except_code  e_code;
    logic [TAG_W-1:0] e_tag;

    // Weighted class mix, loads doubled up
    i_type class_list [0:23] = '{OTHER, LUI, ADD, SUB, XOR, SLL, BEQ, BNE, JAL, JALR,
                                 LB, LBU, LH, LHU, LW, LB, LHU, SB, SH, SW,
                                 CSRRW, ECALL, EBREAK, MRET};

    retire_top #(.TAG_W(TAG_W)) dut_i (
        .clk(clk), .reset(reset), .op_valid(op_valid), .exception(exception),
        .instruction(instruction), .npc(npc), .result0(result0), .result1(result1),
        .jump(jump), .we(we), .tag_in(tag_in), .we_mem(we_mem), .data_in(data_in),
        .i_class(i_class), .irq_pending(irq_pending), .reg_we(reg_we), .wr_data(wr_data),
        .jump_out(jump_out), .new_pc(new_pc), .raise_exception(raise_exception),
        .exception_code(exception_code), .machine_return(machine_return),
        .irq_ack(irq_ack), .curr_tag(curr_tag), .mem_write(mem_write),
        .mem_addr(mem_addr), .mem_data(mem_data), .retired_count(retired_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG);
        $display("Watchdog expired before the run finished");
        $display("Checks failed");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        mismatch_cnt++;
        $display("MISMATCH %s: expected %h, got %h at %0t", name, exp_v, got_v, $time);
    endtask

    task automatic check_wb(input logic exp_we, input logic [31:0] exp_data);
        if (reg_we !== exp_we) report_mismatch("reg_we", exp_we, reg_we);
        if (exp_we && wr_data !== exp_data) report_mismatch("wr_data", exp_data, wr_data);
    endtask

    task automatic check_flow(input logic exp_jump, input logic [31:0] exp_pc,
                              input logic [TAG_W-1:0] exp_tag);
        if (jump_out !== exp_jump) report_mismatch("jump_out", exp_jump, jump_out);
        if (new_pc !== exp_pc) report_mismatch("new_pc", exp_pc, new_pc);
        if (curr_tag !== exp_tag) report_mismatch("curr_tag", exp_tag, curr_tag);
    endtask

    task automatic check_trap(input logic exp_raise, input except_code exp_code,
                              input logic exp_mret, input logic exp_irq);
        if (raise_exception !== exp_raise)
            report_mismatch("raise_exception", exp_raise, raise_exception);
        if (exception_code !== exp_code)
            report_mismatch("exception_code", 32'(exp_code), 32'(exception_code));
        if (machine_return !== exp_mret)
            report_mismatch("machine_return", exp_mret, machine_return);
        if (irq_ack !== exp_irq) report_mismatch("irq_ack", exp_irq, irq_ack);
    endtask

    task automatic check_mem(input logic [3:0] exp_mask, input logic [31:0] exp_addr,
                             input logic [31:0] exp_data,
                             input logic [RET_CNT_W-1:0] exp_cnt);
        if (mem_write !== exp_mask) report_mismatch("mem_write", exp_mask, mem_write);
        if (mem_addr !== exp_addr) report_mismatch("mem_addr", exp_addr, mem_addr);
        if (mem_data !== exp_data) report_mismatch("mem_data", exp_data, mem_data);
        if (retired_count !== exp_cnt)
            report_mismatch("retired_count", exp_cnt, retired_count);
    endtask

    // Register write value from the ISA rules
    function automatic logic [31:0] wb_value(input op_t p);
        if (xu'(p.cls[5:3]) != memory) return p.r0;
        case (p.cls)
            LB:      return {{24{p.din[7]}}, p.din[7:0]};
            LH:      return {{16{p.din[15]}}, p.din[15:0]};
            LBU:     return {24'h0, p.din[7:0]};
            LHU:     return {16'h0, p.din[15:0]};
            LW:      return p.din;
            default: return 32'h0;                  // Stores
        endcase
    endfunction

    task automatic draw_op(input logic idle, output op_t o);
        logic [31:0] rnd;
        logic [31:0] pick;
        rnd     = $random(seed);
        pick    = $random(seed);
        o.valid = !idle && (rnd[2:0] != 3'd0);      // 7 of 8 cycles busy
        o.exc   = (rnd[7:4] == 4'd0);               // Rare illegal op
        o.cls   = class_list[pick[15:0] % 24];
        o.tag   = (rnd[9:8] != 2'd0) ? mdl_tag : mdl_tag - 1'b1;  // Quarter on stale path
        o.jmp   = (xu'(o.cls[5:3]) == branch) && rnd[10];
        o.wen   = rnd[11] && !(o.cls inside {SB, SH, SW});
        case (o.cls)
            SB:      o.wmem = ST_MASK_B0 << rnd[13:12];  // One of four byte lanes
            SH:      o.wmem = rnd[12] ? ST_MASK_H1 : ST_MASK_H0;
            SW:      o.wmem = ST_MASK_W;
            default: o.wmem = 4'h0;
        endcase
        o.instr = $random(seed);
        o.npc   = $random(seed);
        o.r0    = $random(seed);
        o.r1    = $random(seed);
        o.din   = $random(seed);
    endtask

    task automatic drive_op(input op_t o);
        op_valid    = o.valid;
        exception   = o.exc;
        instruction = o.instr;
        npc         = o.npc;
        result0     = o.r0;
        result1     = o.r1;
        jump        = o.jmp;
        we          = o.wen;
        tag_in      = o.tag;
        we_mem      = o.wmem;
        data_in     = o.din;
        i_class     = o.cls;
    endtask

    // One op through the model, irq as seen while it sits in the controller
    task automatic model_step(input op_t p, input logic irq);
        logic live;
        mem_t m;
        live    = p.valid && (p.tag == mdl_tag);
        e_tag   = mdl_tag;
        e_we    = live && p.wen;
        e_data  = wb_value(p);
        e_jump  = live && p.jmp;
        e_pc    = e_jump ? p.r1 : 32'h0;
        e_raise = 1'b0;
        e_code  = NE;
        e_mret  = 1'b0;
        e_irq   = 1'b0;
        if (live) begin
            if (p.exc) begin
                e_raise = 1'b1;
                e_code  = ILLEGAL_INSTRUCTION;
            end else if (p.cls == ECALL) begin
                e_raise = 1'b1;
                e_code  = ECALL_FROM_MMODE;
            end else if (p.cls == EBREAK) begin
                e_raise = 1'b1;
                e_code  = BREAKPOINT;
            end else if (p.cls == MRET) begin
                e_mret = 1'b1;
            end else begin
                e_irq = irq && !p.jmp;              // No ack on a taken branch
            end
            live_cnt = live_cnt + 1'b1;
        end
        if (e_jump || e_raise || e_mret || e_irq) mdl_tag = mdl_tag + 1'b1;
        m.mask  = live ? p.wmem : 4'h0;
        m.addr  = (m.mask != 4'h0) ? p.r1 : 32'h0;
        m.data  = (m.mask != 4'h0) ? p.r0 : 32'h0;
        m.count = live_cnt;
        mem_q.push_back(m);
    endtask

    initial begin : stimulus
        op_t         nxt;
        op_t         cur;
        mem_t        m;
        logic [31:0] rnd;
        int          waited;
        reset       = 1'b0;
        op_valid    = 1'b0;
        exception   = 1'b0;
        instruction = 32'h0;
        npc         = 32'h0;
        result0     = 32'h0;
        result1     = 32'h0;
        jump        = 1'b0;
        we          = 1'b0;
        tag_in      = '0;
        we_mem      = 4'h0;
        data_in     = 32'h0;
        i_class     = OTHER;
        irq_pending = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        check_wb(1'b0, 32'h0);                      // Quiet outputs in reset
        check_flow(1'b0, 32'h0, '0);
        check_trap(1'b0, NE, 1'b0, 1'b0);
        check_mem(4'h0, 32'h0, 32'h0, '0);
        reset = 1'b1;
        mem_q.push_back('{4'h0, 32'h0, 32'h0, '0});  // Port idle from reset
        draw_op(1'b0, nxt);
        drive_op(nxt);
        cur = nxt;
        for (int i = 0; i < NUM_OPS + DRAIN; i++) begin
            @(posedge clk);
            #1;
            rnd         = $random(seed);
            irq_pending = (rnd[2:0] == 3'd0);
            model_step(cur, irq_pending);
            draw_op(i >= NUM_OPS - 1, nxt);         // Tail of the run goes idle
            drive_op(nxt);
            cur = nxt;
            @(negedge clk);
            check_wb(e_we, e_data);
            check_flow(e_jump, e_pc, e_tag);
            check_trap(e_raise, e_code, e_mret, e_irq);
            m = mem_q.pop_front();
            check_mem(m.mask, m.addr, m.data, m.count);
        end
        waited = 0;
        while (retired_count !== live_cnt && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (retired_count !== live_cnt) begin
            fail_cnt++;
            $display("Retired count never reached the model count of %0d", live_cnt);
        end
        $display("Run done: %0d ops, %0d live, %0d mismatches, %0d other errors",
                 NUM_OPS, live_cnt, mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- retire_top.sv
module retire_top #(
    parameter int TAG_W = retire_pkg::TAG_W_DEF
) (
    input  logic                             clk,
    input  logic                             reset,
    // Execute stage
    input  logic                             op_valid,
    input  logic                             exception,
    input  logic [31:0]                      instruction,
    input  logic [31:0]                      npc,
    input  logic [31:0]                      result0,
    input  logic [31:0]                      result1,
    input  logic                             jump,
    input  logic                             we,
    input  logic [TAG_W-1:0]                 tag_in,
    input  logic [3:0]                       we_mem,
    input  logic [31:0]                      data_in,
    input  isa_pkg::i_type                   i_class,
    // Interrupt source
    input  logic                             irq_pending,
    // Register bank, fetch and CSR side
    output logic                             reg_we,
    output logic [31:0]                      wr_data,
    output logic                             jump_out,
    output logic [31:0]                      new_pc,
    output logic                             raise_exception,
    output isa_pkg::except_code              exception_code,
    output logic                             machine_return,
    output logic                             irq_ack,
    output logic [TAG_W-1:0]                 curr_tag,
    // Data memory write port
    output logic [3:0]                       mem_write,
    output logic [31:0]                      mem_addr,
    output logic [31:0]                      mem_data,
    output logic [retire_pkg::RET_CNT_W-1:0] retired_count
);

    retire_op_if #(.TAG_W(TAG_W)) op_bus ();        // Captured op
    commit_if                     cm_bus ();        // Store and retire events

    retire_capture #(.TAG_W(TAG_W)) capture_i (
        .clk         (clk),
        .reset       (reset),
        .op_valid    (op_valid),
        .exception   (exception),
        .instruction (instruction),
        .npc         (npc),
        .result0     (result0),
        .result1     (result1),
        .jump        (jump),
        .we          (we),
        .tag_in      (tag_in),
        .we_mem      (we_mem),
        .data_in     (data_in),
        .i_class     (i_class),
        .op          (op_bus.src)
    );

    retire_ctrl #(.TAG_W(TAG_W)) ctrl_i (
        .clk             (clk),
        .reset           (reset),
        .op              (op_bus.dst),
        .irq_pending     (irq_pending),
        .reg_we          (reg_we),
        .wr_data         (wr_data),
        .jump_out        (jump_out),
        .new_pc          (new_pc),
        .raise_exception (raise_exception),
        .exception_code  (exception_code),
        .machine_return  (machine_return),
        .irq_ack         (irq_ack),
        .curr_tag        (curr_tag),
        .cm              (cm_bus.src)
    );

    retire_commit commit_i (
        .clk           (clk),
        .reset         (reset),
        .cm            (cm_bus.dst),
        .mem_write     (mem_write),
        .mem_addr      (mem_addr),
        .mem_data      (mem_data),
        .retired_count (retired_count)
    );

endmodule

//--- retire_commit.sv
module retire_commit (
    input  logic                           clk,
    input  logic                           reset,
    commit_if.dst                          cm,
    output logic [3:0]                     mem_write,      // Data memory byte enables
    output logic [31:0]                    mem_addr,
    output logic [31:0]                    mem_data,
    output logic [retire_pkg::RET_CNT_W-1:0] retired_count
);
    import retire_pkg::*;

    // Write strobe, zero when no store retires
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mem_write <= '0;
        end else begin
            mem_write <= cm.st_mask;
        end
    end

    // Address and data released to zero when idle
    always_ff @(posedge clk) begin
        if (cm.st_mask != 4'b0000) begin
            mem_addr <= cm.st_addr;
            mem_data <= cm.st_data;
        end else begin
            mem_addr <= '0;
            mem_data <= '0;
        end
    end

    // Live ops only
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            retired_count <= '0;
        end else if (cm.retired) begin
            retired_count <= retired_count + 1'b1;
        end
    end

    // Execute sends only aligned lane patterns
    a_legal_mask: assert property (@(posedge clk) disable iff (!reset)
        (mem_write != 4'b0000) |-> legal_st_mask(mem_write))
        else $error("retire: illegal store mask %b", mem_write);

endmodule

//--- retire_ctrl.sv
module retire_ctrl #(
    parameter int TAG_W = retire_pkg::TAG_W_DEF
) (
    input  logic                clk,
    input  logic                reset,
    retire_op_if.dst            op,
    input  logic                irq_pending,        // Level from interrupt source
    output logic                reg_we,             // Register bank write enable
    output logic [31:0]         wr_data,            // Register bank write data
    output logic                jump_out,           // Redirect fetch
    output logic [31:0]         new_pc,             // Redirect target
    output logic                raise_exception,
    output isa_pkg::except_code exception_code,
    output logic                machine_return,
    output logic                irq_ack,
    output logic [TAG_W-1:0]    curr_tag,
    commit_if.src               cm
);
    import isa_pkg::*;

    logic [TAG_W-1:0] tag_q;                        // Retire tag
    logic             killed;                       // Op is dropped
    logic             flow_change;                  // Live op changes control flow
    xu                xu_sel;                       // Unit that produced the op
    logic [31:0]      load_data;                    // Extended load value

    // Wrong-path ops carry a stale tag
    assign killed = !op.op_valid || (op.tag != tag_q);

    assign xu_sel = xu'(op.i_class[5:3]);

    // Load extension by access width
    always_comb begin
        case (op.i_class)
            LB:      load_data = {{24{op.data_in[7]}}, op.data_in[7:0]};
            LBU:     load_data = {24'h000000, op.data_in[7:0]};
            LH:      load_data = {{16{op.data_in[15]}}, op.data_in[15:0]};
            LHU:     load_data = {16'h0000, op.data_in[15:0]};
            LW:      load_data = op.data_in;
            default: load_data = '0;                // Stores write back nothing
        endcase
    end

    // Write-back
    assign reg_we  = !killed && op.we;
    assign wr_data = (xu_sel == memory) ? load_data : op.result0;

    // Branch redirect
    assign jump_out = !killed && op.jump;
    assign new_pc   = jump_out ? op.result1 : '0;

    // Traps in priority order, interrupt last
    always_comb begin
        raise_exception = 1'b0;
        exception_code  = NE;
        machine_return  = 1'b0;
        irq_ack         = 1'b0;
        if (!killed) begin
            if (op.exception) begin                 // Decode flagged illegal
                raise_exception = 1'b1;
                exception_code  = ILLEGAL_INSTRUCTION;
            end else if (op.i_class == ECALL) begin
                raise_exception = 1'b1;
                exception_code  = ECALL_FROM_MMODE;
            end else if (op.i_class == EBREAK) begin
                raise_exception = 1'b1;
                exception_code  = BREAKPOINT;
            end else if (op.i_class == MRET) begin
                machine_return = 1'b1;
            end else if (irq_pending && !op.jump) begin
                irq_ack = 1'b1;                     // Taken only on a sequential op
            end
        end
    end

    assign flow_change = jump_out || raise_exception || machine_return || irq_ack;

    // Tag moves on every change of flow and wraps
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tag_q <= '0;
        end else if (flow_change) begin
            tag_q <= tag_q + 1'b1;
        end
    end

    assign curr_tag = tag_q;

    // Store request and retire pulse to the output stage
    assign cm.st_mask = killed ? 4'b0000 : op.we_mem;
    assign cm.st_addr = op.result1;
    assign cm.st_data = op.result0;
    assign cm.retired = !killed;

    // At most one trap-type event per op
    a_one_event: assert property (@(posedge clk) disable iff (!reset)
        $onehot0({raise_exception, machine_return, irq_ack}))
        else $error("retire: more than one trap event");

    // An interrupt never lands on a taken branch
    a_no_jump_irq: assert property (@(posedge clk) disable iff (!reset)
        !(jump_out && irq_ack))
        else $error("retire: irq_ack with jump_out");

    // Execute hands over fully known ops under a valid strobe
    a_live_known: assert property (@(posedge clk) disable iff (!reset)
        !killed |-> !$isunknown({op.instruction, op.npc, op.i_class}))
        else $error("retire: live op with unknown fields");

endmodule

//--- retire_capture.sv
module retire_capture #(
    parameter int TAG_W = retire_pkg::TAG_W_DEF
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             op_valid,              // Execute has an op this cycle
    input  logic             exception,
    input  logic [31:0]      instruction,
    input  logic [31:0]      npc,
    input  logic [31:0]      result0,
    input  logic [31:0]      result1,
    input  logic             jump,
    input  logic             we,
    input  logic [TAG_W-1:0] tag_in,
    input  logic [3:0]       we_mem,
    input  logic [31:0]      data_in,
    input  isa_pkg::i_type   i_class,
    retire_op_if.src         op
);

    // Valid strobe is the only control bit here
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            op.op_valid <= 1'b0;                    // Nothing to retire out of reset
        end else begin
            op.op_valid <= op_valid;
        end
    end

    // Operation payload, qualified by op_valid downstream
    always_ff @(posedge clk) begin
        op.exception   <= exception;
        op.instruction <= instruction;
        op.npc         <= npc;
        op.result0     <= result0;
        op.result1     <= result1;
        op.jump        <= jump;
        op.we          <= we;
        op.tag         <= tag_in;
        op.we_mem      <= we_mem;
        op.data_in     <= data_in;                  // Load data arrives with the op
        op.i_class     <= i_class;
    end

endmodule

//--- commit_if.sv
interface commit_if ();

    logic [3:0]  st_mask;                           // Store lanes, zero when no store
    logic [31:0] st_addr;                           // Store address
    logic [31:0] st_data;                           // Store data
    logic        retired;                           // One live op retired this cycle

    // Controller side
    modport src (
        output st_mask,
        output st_addr,
        output st_data,
        output retired
    );

    // Output stage side
    modport dst (
        input  st_mask,
        input  st_addr,
        input  st_data,
        input  retired
    );

endinterface

//--- retire_op_if.sv
interface retire_op_if #(
    parameter int TAG_W = retire_pkg::TAG_W_DEF
) ();
    import isa_pkg::*;

    logic             op_valid;                     // Captured execute strobe
    logic             exception;                    // Illegal instruction flag
    logic [31:0]      instruction;                  // Raw instruction word
    logic [31:0]      npc;                          // PC of the operation
    logic [31:0]      result0;                      // Write-back or store data
    logic [31:0]      result1;                      // Branch target or store address
    logic             jump;                         // Branch taken
    logic             we;                           // Register write request
    logic [TAG_W-1:0] tag;                          // Tag given at fetch
    logic [3:0]       we_mem;                       // Store byte lanes
    logic [31:0]      data_in;                      // Load data from memory
    i_type            i_class;                      // Decoded class

    modport src (
        output op_valid, exception, instruction, npc,
        output result0, result1, jump, we,
        output tag, we_mem, data_in, i_class
    );

    modport dst (
        input  op_valid, exception, instruction, npc,
        input  result0, result1, jump, we,
        input  tag, we_mem, data_in, i_class
    );

endinterface

//--- retire_pkg.sv
package retire_pkg;

    localparam int TAG_W_DEF = 4;                   // Retire tag bits
    localparam int RET_CNT_W = 32;                  // Retired-op counter bits

    // Byte lanes of a store
    localparam logic [3:0] ST_MASK_B0 = 4'b0001;
    localparam logic [3:0] ST_MASK_B1 = 4'b0010;
    localparam logic [3:0] ST_MASK_B2 = 4'b0100;
    localparam logic [3:0] ST_MASK_B3 = 4'b1000;

    // Half-word lanes
    localparam logic [3:0] ST_MASK_H0 = 4'b0011;
    localparam logic [3:0] ST_MASK_H1 = 4'b1100;

    // Whole word
    localparam logic [3:0] ST_MASK_W  = 4'b1111;

    // True for an aligned byte, half or word mask
    function automatic logic legal_st_mask(input logic [3:0] mask);
        return mask inside {ST_MASK_B0, ST_MASK_B1, ST_MASK_B2, ST_MASK_B3,
                            ST_MASK_H0, ST_MASK_H1, ST_MASK_W};
    endfunction

endpackage

//--- isa_pkg.sv
package isa_pkg;

    // Execution unit, taken from bits 5:3 of the instruction class
    typedef enum logic [2:0] {
        bypass  = 3'b000,                           // Immediate pass-through
        alu     = 3'b001,                           // Add, sub, compares
        logical = 3'b010,                           // And, or, xor
        shifter = 3'b011,                           // Shifts
        branch  = 3'b100,                           // Branches and jumps
        memory  = 3'b101,                           // Loads and stores
        csr     = 3'b110,                           // CSR access
        sys     = 3'b111                            // Environment calls, MRET
    } xu;

    // Instruction class, unit in the upper 3 bits, operation in the lower 3
    typedef enum logic [5:0] {
        OTHER = 6'b000_000, LUI   = 6'b000_001,     // Bypass unit
        ADD   = 6'b001_000, SUB   = 6'b001_001,     // ALU
        SLT   = 6'b001_010, SLTU  = 6'b001_011,
        XOR   = 6'b010_000, OR    = 6'b010_001,     // Logical unit
        AND   = 6'b010_010,
        SLL   = 6'b011_000, SRL   = 6'b011_001,     // Shifter
        SRA   = 6'b011_010,
        BEQ   = 6'b100_000, BNE   = 6'b100_001,     // Branch unit
        BLT   = 6'b100_010, BLTU  = 6'b100_011,
        BGE   = 6'b100_100, BGEU  = 6'b100_101,
        JAL   = 6'b100_110, JALR  = 6'b100_111,
        LB    = 6'b101_000, LBU   = 6'b101_001,     // Memory loads
        LH    = 6'b101_010, LHU   = 6'b101_011,
        LW    = 6'b101_100,
        SB    = 6'b101_101, SH    = 6'b101_110,     // Memory stores
        SW    = 6'b101_111,
        CSRRW = 6'b110_000, CSRRS = 6'b110_001,     // CSR unit
        CSRRC = 6'b110_010,
        ECALL = 6'b111_000, EBREAK = 6'b111_001,    // System
        MRET  = 6'b111_010
    } i_type;

    // Machine cause codes that retire can raise
    typedef enum logic [3:0] {
        NE                  = 4'd0,                 // Nothing to report
        ILLEGAL_INSTRUCTION = 4'd2,
        BREAKPOINT          = 4'd3,
        ECALL_FROM_MMODE    = 4'd11
    } except_code;

endpackage
